// ==== all.f ====
+incdir+hw
hw/ccip_shim_pkg.sv
hw/ccip_afifo_channel.sv
hw/ccip_chan_xfer.sv
hw/ccip_async_shim.sv
sim/ccip_async_shim_sva.sv
sim/tb_ccip_async_shim.sv

// ==== hw/ccip_afifo_channel.sv ====
`timescale 1ns/1ps

module ccip_afifo_channel
   import ccip_shim_pkg::*;
   #(
   parameter type T_DATA      = t_c0_req,
   parameter int  DEPTH_RADIX = 8
   )
   (
   input  logic                   wrclk,
   input  logic                   wrrst,
   input  logic                   wrreq,
   input  T_DATA                  data,
   input  logic                   rdclk,
   input  logic                   rdrst,
   input  logic                   rdreq,
   output T_DATA                  q,
   output logic                   rdempty,
   output logic [DEPTH_RADIX-1:0] wrusedw
   );

   localparam int DEPTH = 1 << DEPTH_RADIX;
   localparam int PW    = DEPTH_RADIX + 1;   // One extra bit tells full from empty.

   T_DATA mem [DEPTH];

   logic [PW-1:0] wr_bin;
   logic [PW-1:0] wr_bin_next;
   logic [PW-1:0] wr_gray;
   logic [PW-1:0] rd_gray_s1;
   logic [PW-1:0] rd_gray_s2;
   logic [PW-1:0] wr_used;
   logic          wr_fire;

   logic [PW-1:0] rd_bin;
   logic [PW-1:0] rd_bin_next;
   logic [PW-1:0] rd_gray;
   logic [PW-1:0] rd_gray_next;
   logic [PW-1:0] wr_gray_s1;
   logic [PW-1:0] wr_gray_s2;
   logic          rd_fire;

   function automatic logic [PW-1:0] bin2gray(input logic [PW-1:0] b);
      return b ^ (b >> 1);
   endfunction

   function automatic logic [PW-1:0] gray2bin(input logic [PW-1:0] g);
      logic [PW-1:0] b;
      b[PW-1] = g[PW-1];
      for (int i = PW - 2; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // Write side. Count is against the synchronized read pointer, so it reads high.
   assign wr_used     = wr_bin - gray2bin(rd_gray_s2);
   assign wrusedw     = wr_used[DEPTH_RADIX-1:0];
   assign wr_fire     = wrreq & ~wr_used[PW-1];   // A write into a full FIFO is dropped.
   assign wr_bin_next = wr_bin + PW'(wr_fire);

   always_ff @(posedge wrclk) begin
      if (wr_fire) begin
         mem[wr_bin[DEPTH_RADIX-1:0]] <= data;
      end
   end

   always_ff @(posedge wrclk) begin
      if (wrrst) begin
         wr_bin     <= '0;
         wr_gray    <= '0;
         rd_gray_s1 <= '0;
         rd_gray_s2 <= '0;
      end
      else begin
         wr_bin     <= wr_bin_next;
         wr_gray    <= bin2gray(wr_bin_next);
         rd_gray_s1 <= rd_gray;
         rd_gray_s2 <= rd_gray_s1;
      end
   end

   // Read side. Data shows up on q the cycle after the pop.
   assign rd_fire      = rdreq & ~rdempty;
   assign rd_bin_next  = rd_bin + PW'(rd_fire);
   assign rd_gray_next = bin2gray(rd_bin_next);

   always_ff @(posedge rdclk) begin
      if (rd_fire) begin
         q <= mem[rd_bin[DEPTH_RADIX-1:0]];
      end
   end

   always_ff @(posedge rdclk) begin
      if (rdrst) begin
         rd_bin     <= '0;
         rd_gray    <= '0;
         wr_gray_s1 <= '0;
         wr_gray_s2 <= '0;
         rdempty    <= 1'b1;
      end
      else begin
         rd_bin     <= rd_bin_next;
         rd_gray    <= rd_gray_next;
         wr_gray_s1 <= wr_gray;
         wr_gray_s2 <= wr_gray_s1;
         rdempty    <= (rd_gray_next == wr_gray_s2);
      end
   end

endmodule

// ==== hw/ccip_async_shim.sv ====
`timescale 1ns/1ps
`include "ccip_shim_macros.svh"

module ccip_async_shim
   import ccip_shim_pkg::*;
   (
   input  logic    bb_clk,
   input  logic    afu_clk,
   input  logic    afu_softreset,
   output logic    afu_reset,

   input  logic    afu_c0_req_valid,
   input  t_c0_req afu_c0_req,
   input  logic    afu_c1_req_valid,
   input  t_c1_req afu_c1_req,
   input  logic    afu_c2_rsp_valid,
   input  t_c2_rsp afu_c2_rsp,
   output logic    afu_c0_almfull,
   output logic    afu_c1_almfull,
   output logic    afu_c0_rx_valid,
   output t_c0_rx  afu_c0_rx,
   output logic    afu_c1_rx_valid,
   output t_c1_rx  afu_c1_rx,

   output logic    bb_c0_req_valid,
   output t_c0_req bb_c0_req,
   output logic    bb_c1_req_valid,
   output t_c1_req bb_c1_req,
   output logic    bb_c2_rsp_valid,
   output t_c2_rsp bb_c2_rsp,
   input  logic    bb_c0_almfull,
   input  logic    bb_c1_almfull,
   input  logic    bb_c0_rx_valid,
   input  t_c0_rx  bb_c0_rx,
   input  logic    bb_c1_rx_valid,
   input  t_c1_rx  bb_c1_rx
   );

   logic    afu_rst_s1;
   logic    afu_rst_s2;

   logic    c0_req_valid_q;
   t_c0_req c0_req_q;
   logic    c1_req_valid_q;
   t_c1_req c1_req_q;
   logic    c2_rsp_valid_q;
   t_c2_rsp c2_rsp_q;
   logic    c0_almfull_q;
   logic    c1_almfull_q;
   logic    c0_rx_valid_q;
   t_c0_rx  c0_rx_q;
   logic    c1_rx_valid_q;
   t_c1_rx  c1_rx_q;

   logic    tx0_valid;
   t_c0_req tx0_data;
   logic    tx0_almfull;
   logic    tx1_valid;
   t_c1_req tx1_data;
   logic    tx1_almfull;
   logic    tx2_valid;
   t_c2_rsp tx2_data;
   logic    rx0_valid;
   t_c0_rx  rx0_data;
   logic    rx1_valid;
   t_c1_rx  rx1_data;

   // Host reset into the AFU domain.
   always_ff @(posedge afu_clk) begin
      afu_rst_s1 <= afu_softreset;
      afu_rst_s2 <= afu_rst_s1;
      afu_reset  <= afu_rst_s2;
   end

   always_ff @(posedge afu_clk) begin
      if (afu_reset) begin
         c0_req_valid_q  <= 1'b0;
         c1_req_valid_q  <= 1'b0;
         c2_rsp_valid_q  <= 1'b0;
         afu_c0_almfull  <= 1'b0;
         afu_c1_almfull  <= 1'b0;
         afu_c0_rx_valid <= 1'b0;
         afu_c1_rx_valid <= 1'b0;
      end
      else begin
         c0_req_valid_q  <= afu_c0_req_valid;
         c1_req_valid_q  <= afu_c1_req_valid;
         c2_rsp_valid_q  <= afu_c2_rsp_valid;
         afu_c0_almfull  <= tx0_almfull;
         afu_c1_almfull  <= tx1_almfull;
         afu_c0_rx_valid <= rx0_valid;
         afu_c1_rx_valid <= rx1_valid;
      end
   end

   always_ff @(posedge afu_clk) begin
      c0_req_q  <= afu_c0_req;
      c1_req_q  <= afu_c1_req;
      c2_rsp_q  <= afu_c2_rsp;
      afu_c0_rx <= rx0_data;
      afu_c1_rx <= rx1_data;
   end

   always_ff @(posedge bb_clk) begin
      if (afu_softreset) begin
         c0_almfull_q    <= 1'b0;
         c1_almfull_q    <= 1'b0;
         c0_rx_valid_q   <= 1'b0;
         c1_rx_valid_q   <= 1'b0;
         bb_c0_req_valid <= 1'b0;
         bb_c1_req_valid <= 1'b0;
         bb_c2_rsp_valid <= 1'b0;
      end
      else begin
         c0_almfull_q    <= bb_c0_almfull;
         c1_almfull_q    <= bb_c1_almfull;
         c0_rx_valid_q   <= bb_c0_rx_valid;
         c1_rx_valid_q   <= bb_c1_rx_valid;
         bb_c0_req_valid <= tx0_valid;
         bb_c1_req_valid <= tx1_valid;
         bb_c2_rsp_valid <= tx2_valid;
      end
   end

   always_ff @(posedge bb_clk) begin
      c0_rx_q   <= bb_c0_rx;
      c1_rx_q   <= bb_c1_rx;
      bb_c0_req <= tx0_data;
      bb_c1_req <= tx1_data;
      bb_c2_rsp <= tx2_data;
   end

   ccip_chan_xfer #(.T_PAYLOAD(t_c0_req), .DEPTH_RADIX(`CCIP_TX_RADIX), .FLOW_CTRL(1'b1))
   tx0_xfer (
      .src_clk (afu_clk), .src_rst (afu_reset), .src_valid (c0_req_valid_q),
      .src_data (c0_req_q), .dst_clk (bb_clk), .dst_rst (afu_softreset),
      .dst_almfull (c0_almfull_q), .dst_valid (tx0_valid), .dst_data (tx0_data),
      .src_almfull (tx0_almfull)
   );

   ccip_chan_xfer #(.T_PAYLOAD(t_c1_req), .DEPTH_RADIX(`CCIP_TX_RADIX), .FLOW_CTRL(1'b1))
   tx1_xfer (
      .src_clk (afu_clk), .src_rst (afu_reset), .src_valid (c1_req_valid_q),
      .src_data (c1_req_q), .dst_clk (bb_clk), .dst_rst (afu_softreset),
      .dst_almfull (c1_almfull_q), .dst_valid (tx1_valid), .dst_data (tx1_data),
      .src_almfull (tx1_almfull)
   );

   // MMIO responses and both rx channels always drain.
   ccip_chan_xfer #(.T_PAYLOAD(t_c2_rsp), .DEPTH_RADIX(`CCIP_TX_RADIX), .FLOW_CTRL(1'b0))
   tx2_xfer (
      .src_clk (afu_clk), .src_rst (afu_reset), .src_valid (c2_rsp_valid_q),
      .src_data (c2_rsp_q), .dst_clk (bb_clk), .dst_rst (afu_softreset),
      .dst_almfull (1'b0), .dst_valid (tx2_valid), .dst_data (tx2_data),
      .src_almfull ()
   );

   ccip_chan_xfer #(.T_PAYLOAD(t_c0_rx), .DEPTH_RADIX(`CCIP_RX0_RADIX), .FLOW_CTRL(1'b0))
   rx0_xfer (
      .src_clk (bb_clk), .src_rst (afu_softreset), .src_valid (c0_rx_valid_q),
      .src_data (c0_rx_q), .dst_clk (afu_clk), .dst_rst (afu_reset),
      .dst_almfull (1'b0), .dst_valid (rx0_valid), .dst_data (rx0_data),
      .src_almfull ()
   );

   ccip_chan_xfer #(.T_PAYLOAD(t_c1_rx), .DEPTH_RADIX(`CCIP_RX1_RADIX), .FLOW_CTRL(1'b0))
   rx1_xfer (
      .src_clk (bb_clk), .src_rst (afu_softreset), .src_valid (c1_rx_valid_q),
      .src_data (c1_rx_q), .dst_clk (afu_clk), .dst_rst (afu_reset),
      .dst_almfull (1'b0), .dst_valid (rx1_valid), .dst_data (rx1_data),
      .src_almfull ()
   );

endmodule

// ==== hw/ccip_chan_xfer.sv ====
`timescale 1ns/1ps
`include "ccip_shim_macros.svh"

module ccip_chan_xfer
   import ccip_shim_pkg::*;
   #(
   parameter type T_PAYLOAD   = t_c0_req,
   parameter int  DEPTH_RADIX = `CCIP_TX_RADIX,
   parameter bit  FLOW_CTRL   = 1'b0
   )
   (
   input  logic     src_clk,
   input  logic     src_rst,
   input  logic     src_valid,
   input  T_PAYLOAD src_data,
   input  logic     dst_clk,
   input  logic     dst_rst,
   input  logic     dst_almfull,
   output logic     dst_valid,
   output T_PAYLOAD dst_data,
   output logic     src_almfull
   );

   T_PAYLOAD               fifo_q;
   logic                   rdempty;
   logic                   rdempty_q;
   logic                   rdreq;
   logic                   rd_hold;
   logic                   fifo_rdreq;
   logic                   rd_valid;
   logic [DEPTH_RADIX-1:0] wrusedw;

   ccip_afifo_channel #(
      .T_DATA      (T_PAYLOAD),
      .DEPTH_RADIX (DEPTH_RADIX)
   ) afifo (
      .wrclk   (src_clk),
      .wrrst   (src_rst),
      .wrreq   (src_valid),
      .data    (src_data),
      .rdclk   (dst_clk),
      .rdrst   (dst_rst),
      .rdreq   (fifo_rdreq),
      .q       (fifo_q),
      .rdempty (rdempty),
      .wrusedw (wrusedw)
   );

   assign rd_hold    = FLOW_CTRL && dst_almfull;
   assign fifo_rdreq = rdreq & ~rd_hold;   // Also stops a request already registered.

   generate
      if (`CCIP_EXTRA_PIPE == 1) begin : g_empty_pipe
         always_ff @(posedge dst_clk) begin
            if (dst_rst) begin
               rdempty_q <= 1'b1;
            end
            else begin
               rdempty_q <= rdempty;
            end
         end
      end
      else begin : g_empty_comb
         assign rdempty_q = rdempty;
      end
   endgenerate

   always_ff @(posedge dst_clk) begin
      if (dst_rst) begin
         rdreq     <= 1'b0;
         rd_valid  <= 1'b0;
         dst_valid <= 1'b0;
      end
      else begin
         rdreq     <= ~rdempty_q & ~rd_hold;
         rd_valid  <= fifo_rdreq & ~rdempty;   // Pop happened, q is good next cycle.
         dst_valid <= rd_valid;
      end
   end

   always_ff @(posedge dst_clk) begin
      if (rd_valid) begin
         dst_data <= fifo_q;
      end
      else begin
         dst_data <= '0;   // Idle bus reads as zero.
      end
   end

   generate
      if (FLOW_CTRL) begin : g_almfull
         always_ff @(posedge src_clk) begin
            if (src_rst) begin
               src_almfull <= 1'b0;
            end
            else begin
               src_almfull <= |wrusedw[DEPTH_RADIX-1:DEPTH_RADIX-2];   // Quarter full or more.
            end
         end
      end
      else begin : g_no_almfull
         assign src_almfull = 1'b0;
      end
   endgenerate

endmodule

// ==== hw/ccip_shim_macros.svh ====
`ifndef CCIP_SHIM_MACROS_SVH
`define CCIP_SHIM_MACROS_SVH

// Reduced cache line.
`define CCIP_DATA_WIDTH 64

// Tx FIFOs hold 256 entries, so almost-full trips at 64.
`define CCIP_TX_RADIX 8

`define CCIP_RX0_RADIX 10

`define CCIP_RX1_RADIX 9

// Set to 1 to retime the read-side empty flag.
`define CCIP_EXTRA_PIPE 1

`endif

// ==== hw/ccip_shim_pkg.sv ====
`include "ccip_shim_macros.svh"

package ccip_shim_pkg;

   // Memory read request, AFU to host.
   typedef struct packed {
      logic [41:0] addr;
      logic [15:0] mdata;
   } t_c0_req;

   typedef struct packed {
      logic [41:0]                 addr;
      logic [15:0]                 mdata;
      logic [`CCIP_DATA_WIDTH-1:0] data;
   } t_c1_req;

   typedef struct packed {
      logic [8:0]                  tid;   // Tag of the MMIO read being answered.
      logic [`CCIP_DATA_WIDTH-1:0] data;
   } t_c2_rsp;

   typedef enum logic [1:0] {
      rx_mem_rsp = 2'd0,
      rx_mmio_rd = 2'd1,
      rx_mmio_wr = 2'd2
   } t_c0_rx_kind;

   typedef struct packed {
      t_c0_rx_kind                 kind;
      logic [15:0]                 mdata;
      logic [`CCIP_DATA_WIDTH-1:0] data;
   } t_c0_rx;

   // Write completion, host to AFU.
   typedef struct packed {
      logic [15:0] mdata;
   } t_c1_rx;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and pass only if the testbench reports success.
verilator --binary --timing --assert -f all.f --top-module tb_ccip_async_shim \
   && ./obj_dir/Vtb_ccip_async_shim +verilator+error+limit+100 \
      | tee /dev/stderr \
      | grep "Everything OK" > /dev/null \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

// ==== sim/ccip_async_shim_sva.sv ====
`timescale 1ns/1ps

module ccip_async_shim_sva (
   input logic bb_clk,
   input logic afu_clk,
   input logic afu_softreset,
   input logic afu_reset,
   input logic bb_c0_req_valid,
   input logic bb_c1_req_valid,
   input logic bb_c2_rsp_valid,
   input logic bb_c0_almfull,
   input logic bb_c1_almfull,
   input logic afu_c0_rx_valid,
   input logic afu_c1_rx_valid,
   input logic afu_c0_almfull,
   input logic afu_c1_almfull
);

   int fail_count = 0;

   // Output registers clear one cycle after reset is seen.
   host_valid_in_reset: assert property (@(posedge bb_clk)
      afu_softreset |=> !(bb_c0_req_valid | bb_c1_req_valid | bb_c2_rsp_valid))
      else begin
         fail_count++;
         $error("Host valid high while afu_softreset is active");
      end

   afu_valid_in_reset: assert property (@(posedge afu_clk)
      afu_reset |=> !(afu_c0_rx_valid | afu_c1_rx_valid))
      else begin
         fail_count++;
         $error("AFU valid high while afu_reset is active");
      end

   // Five cycles of almost-full cover the input register and the read pipeline.
   c0_backpressure: assert property (@(posedge bb_clk) disable iff (afu_softreset)
      bb_c0_almfull && $past(bb_c0_almfull, 1) && $past(bb_c0_almfull, 2)
         && $past(bb_c0_almfull, 3) && $past(bb_c0_almfull, 4) |-> !bb_c0_req_valid)
      else begin
         fail_count++;
         $error("bb_c0_req_valid high after five cycles of bb_c0_almfull");
      end

   c1_backpressure: assert property (@(posedge bb_clk) disable iff (afu_softreset)
      bb_c1_almfull && $past(bb_c1_almfull, 1) && $past(bb_c1_almfull, 2)
         && $past(bb_c1_almfull, 3) && $past(bb_c1_almfull, 4) |-> !bb_c1_req_valid)
      else begin
         fail_count++;
         $error("bb_c1_req_valid high after five cycles of bb_c1_almfull");
      end

   almfull_in_reset: assert property (@(posedge afu_clk)
      afu_reset |=> !(afu_c0_almfull | afu_c1_almfull))
      else begin
         fail_count++;
         $error("AFU almost-full high while afu_reset is active");
      end

endmodule

// ==== sim/tb_ccip_async_shim.sv ====
`timescale 1ns/1ps

module tb_ccip_async_shim
   import ccip_shim_pkg::*;
   ();

   localparam int NUM_TESTS = 7;

   logic    bb_clk;
   logic    afu_clk;
   logic    afu_softreset;
   logic    afu_reset;
   logic    afu_c0_req_valid;
   t_c0_req afu_c0_req;
   logic    afu_c1_req_valid;
   t_c1_req afu_c1_req;
   logic    afu_c2_rsp_valid;
   t_c2_rsp afu_c2_rsp;
   logic    afu_c0_almfull;
   logic    afu_c1_almfull;
   logic    afu_c0_rx_valid;
   t_c0_rx  afu_c0_rx;
   logic    afu_c1_rx_valid;
   t_c1_rx  afu_c1_rx;
   logic    bb_c0_req_valid;
   t_c0_req bb_c0_req;
   logic    bb_c1_req_valid;
   t_c1_req bb_c1_req;
   logic    bb_c2_rsp_valid;
   t_c2_rsp bb_c2_rsp;
   logic    bb_c0_almfull;
   logic    bb_c1_almfull;
   logic    bb_c0_rx_valid;
   t_c0_rx  bb_c0_rx;
   logic    bb_c1_rx_valid;
   t_c1_rx  bb_c1_rx;

   t_c0_req exp_tx0 [$];
   t_c1_req exp_tx1 [$];
   t_c2_rsp exp_tx2 [$];
   t_c0_rx  exp_rx0 [$];
   t_c1_rx  exp_rx1 [$];

   // Channels: 0..2 are tx c0..c2, 3 and 4 are rx c0 and c1.
   string test_name  [NUM_TESTS] = '{"tx_c0_reads", "tx_c1_writes", "tx_c2_mmio",
                                     "rx_c0_mixed", "rx_c1_cpl", "tx_c0_backpressure",
                                     "tx_c1_backpressure"};
   int    test_chan  [NUM_TESTS] = '{0, 1, 2, 3, 4, 0, 1};
   int    test_count [NUM_TESTS] = '{24, 24, 16, 30, 20, 70, 70};
   bit    test_bp    [NUM_TESTS] = '{0, 0, 0, 0, 0, 1, 1};

   int     err_seq  = 0;
   int     err_host = 0;
   int     err_afu  = 0;
   integer seed;
   string  cur_test = "reset";
   logic   hold_c0  = 1'b0;   // Host c0 valid must stay low while set.
   logic   hold_c1  = 1'b0;   // Host c1 valid must stay low while set.

   ccip_async_shim UUT (.*);

   bind ccip_async_shim ccip_async_shim_sva sva_chk (.*);

   initial begin
      bb_clk = 1'b0;
      forever #2 bb_clk = ~bb_clk;
   end

   initial begin
      afu_clk = 1'b0;
      forever #3 afu_clk = ~afu_clk;
   end

   function automatic logic [127:0] rand_bits();
      return {$random(seed), $random(seed), $random(seed), $random(seed)};
   endfunction

   function automatic int pending();
      return exp_tx0.size() + exp_tx1.size() + exp_tx2.size() + exp_rx0.size()
             + exp_rx1.size();
   endfunction

   function automatic logic probe(input int sel);
      return (sel == 0) ? afu_reset : (sel == 1) ? afu_c0_almfull : afu_c1_almfull;
   endfunction

   task automatic check_item(input string chan, input logic [127:0] exp_val,
                             input logic [127:0] act_val, inout int errs);
      assert (act_val === exp_val) else begin
         errs++;
         $display("ERR %s %s: expected %h, actual %h", cur_test, chan, exp_val, act_val);
      end
   endtask

   task automatic check_pending(input string chan, input int size, inout int errs);
      assert (size > 0) else begin
         errs++;
         $display("%s: %s delivered an item that was never sent", cur_test, chan);
      end
   endtask

   task automatic wait_level(input string what, input int sel, input logic level,
                             input int limit);
      int n;
      n = 0;
      while (probe(sel) !== level && n < limit) begin
         @(negedge afu_clk);
         n++;
      end
      assert (probe(sel) === level) else begin
         err_seq++;
         $display("%s: timed out waiting for %s", cur_test, what);
      end
   endtask

   // Sampled on afu_clk rising edges, away from every monitor edge.
   task automatic wait_drained(input int limit);
      int n;
      n = 0;
      while (pending() != 0 && n < limit) begin
         @(posedge afu_clk);
         n++;
      end
      assert (pending() == 0) else begin
         err_seq++;
         $display("%s: timed out with %0d items never delivered", cur_test, pending());
      end
   endtask

   task automatic send_item(input int chan, input int idx);
      logic [127:0] r;
      r = rand_bits();
      if (chan < 3) begin
         @(negedge afu_clk);
      end
      else begin
         @(negedge bb_clk);
      end
      case (chan)
         0: begin
            afu_c0_req_valid = 1'b1;
            afu_c0_req       = r[$bits(t_c0_req)-1:0];
            exp_tx0.push_back(afu_c0_req);
         end
         1: begin
            afu_c1_req_valid = 1'b1;
            afu_c1_req       = r[$bits(t_c1_req)-1:0];
            exp_tx1.push_back(afu_c1_req);
         end
         2: begin
            afu_c2_rsp_valid = 1'b1;
            afu_c2_rsp       = r[$bits(t_c2_rsp)-1:0];
            exp_tx2.push_back(afu_c2_rsp);
         end
         3: begin
            bb_c0_rx_valid = 1'b1;
            bb_c0_rx       = r[$bits(t_c0_rx)-1:0];
            bb_c0_rx.kind  = t_c0_rx_kind'(2'(idx % 3));   // All three kinds in turn.
            exp_rx0.push_back(bb_c0_rx);
         end
         default: begin
            bb_c1_rx_valid = 1'b1;
            bb_c1_rx       = r[$bits(t_c1_rx)-1:0];
            exp_rx1.push_back(bb_c1_rx);
         end
      endcase
      if (chan < 3) begin
         @(negedge afu_clk);
         {afu_c0_req_valid, afu_c1_req_valid, afu_c2_rsp_valid} = 3'b000;
      end
      else begin
         @(negedge bb_clk);
         {bb_c0_rx_valid, bb_c1_rx_valid} = 2'b00;
      end
   endtask

   task automatic run_backpressure(input int chan, input int count);
      @(negedge bb_clk);
      bb_c0_almfull = (chan == 0);
      bb_c1_almfull = (chan == 1);
      repeat (4) @(negedge bb_clk);   // Let the almost-full reach the read side.
      hold_c0 = bb_c0_almfull;
      hold_c1 = bb_c1_almfull;
      for (int i = 0; i < count; i++) begin
         send_item(chan, i);
      end
      wait_level("afu almost-full to rise", chan + 1, 1'b1, 50);
      @(negedge bb_clk);
      hold_c0       = 1'b0;
      hold_c1       = 1'b0;
      bb_c0_almfull = 1'b0;
      bb_c1_almfull = 1'b0;
      wait_drained(3000);
      wait_level("afu almost-full to fall", chan + 1, 1'b0, 200);
   endtask

   initial begin
      afu_softreset    = 1'b1;
      seed             = 32'h98add022;
      afu_c0_req_valid = 1'b0;
      afu_c1_req_valid = 1'b0;
      afu_c2_rsp_valid = 1'b0;
      afu_c0_req       = '0;
      afu_c1_req       = '0;
      afu_c2_rsp       = '0;
      bb_c0_almfull    = 1'b0;
      bb_c1_almfull    = 1'b0;
      bb_c0_rx_valid   = 1'b0;
      bb_c1_rx_valid   = 1'b0;
      bb_c0_rx         = '0;
      bb_c1_rx         = '0;
      repeat (2) @(negedge bb_clk);
      afu_softreset = 1'b0;
      wait_level("afu_reset to rise", 0, 1'b1, 20);
      wait_level("afu_reset to fall", 0, 1'b0, 20);
      check_item("outputs", 128'(0), 128'({bb_c0_req_valid, bb_c1_req_valid,
                 bb_c2_rsp_valid, afu_c0_rx_valid, afu_c1_rx_valid, afu_c0_almfull,
                 afu_c1_almfull}), err_seq);
      for (int t = 0; t < NUM_TESTS; t++) begin
         cur_test = test_name[t];
         if (test_bp[t]) begin
            run_backpressure(test_chan[t], test_count[t]);
         end
         else begin
            for (int i = 0; i < test_count[t]; i++) begin
               send_item(test_chan[t], i);
            end
            wait_drained(3000);
         end
      end
      $display("Error counts: sequence %0d, host side %0d, AFU side %0d, assertions %0d",
               err_seq, err_host, err_afu, UUT.sva_chk.fail_count);
      if (err_seq + err_host + err_afu + UUT.sva_chk.fail_count == 0) begin
         $display("Everything OK");
      end
      else begin
         $display("Something failed");
      end
      $finish;
   end

   always @(negedge bb_clk) begin
      if (bb_c0_req_valid) begin
         check_pending("tx_c0", exp_tx0.size(), err_host);
         if (exp_tx0.size() > 0) begin
            check_item("tx_c0", 128'(exp_tx0.pop_front()), 128'(bb_c0_req), err_host);
         end
      end
      if (bb_c1_req_valid) begin
         check_pending("tx_c1", exp_tx1.size(), err_host);
         if (exp_tx1.size() > 0) begin
            check_item("tx_c1", 128'(exp_tx1.pop_front()), 128'(bb_c1_req), err_host);
         end
      end
      if (bb_c2_rsp_valid) begin
         check_pending("tx_c2", exp_tx2.size(), err_host);
         if (exp_tx2.size() > 0) begin
            check_item("tx_c2", 128'(exp_tx2.pop_front()), 128'(bb_c2_rsp), err_host);
         end
      end
      if (hold_c0) begin
         check_item("tx_c0_hold", 128'(0), 128'(bb_c0_req_valid), err_host);
      end
      if (hold_c1) begin
         check_item("tx_c1_hold", 128'(0), 128'(bb_c1_req_valid), err_host);
      end
   end

   always @(negedge afu_clk) begin
      if (afu_c0_rx_valid) begin
         check_pending("rx_c0", exp_rx0.size(), err_afu);
         if (exp_rx0.size() > 0) begin
            check_item("rx_c0", 128'(exp_rx0.pop_front()), 128'(afu_c0_rx), err_afu);
         end
      end
      if (afu_c1_rx_valid) begin
         check_pending("rx_c1", exp_rx1.size(), err_afu);
         if (exp_rx1.size() > 0) begin
            check_item("rx_c1", 128'(exp_rx1.pop_front()), 128'(afu_c1_rx), err_afu);
         end
      end
   end

endmodule
